//--- design/cache_defs.svh
//--------------------------------------------------------------------------
// Size parameters of the data cache storage block. Included by the
// package and by every array that sizes its storage from these values.
//--------------------------------------------------------------------------

`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

//--------------------------------------------------------------------------
// Address and line geometry
//--------------------------------------------------------------------------

// Width of a full byte address as seen by the lookup port
`define CACHE_ADDR_WIDTH 32

// Number of lines in the direct-mapped cache
`define CACHE_DEPTH 64

//--------------------------------------------------------------------------
// Data organisation
//--------------------------------------------------------------------------

// Words held by one line, a power of two
`define CACHE_WORDS 4

// Width of one data word in bits, a whole number of bytes
`define CACHE_WORD_WIDTH 32

`endif

//--- design/cache_pkg.sv
//--------------------------------------------------------------------------
// Shared types of the cache storage block: address fields, data words
// and the structs carried by the update and lookup ports.
//--------------------------------------------------------------------------

`include "cache_defs.svh"

package cache_pkg;

    // Field widths derived from the geometry macros
    localparam int INDEX_WIDTH  = $clog2(`CACHE_DEPTH);
    localparam int OFFSET_WIDTH = $clog2(`CACHE_WORDS);
    localparam int BYTE_WIDTH   = $clog2(`CACHE_WORD_WIDTH / 8);
    localparam int TAG_WIDTH    = `CACHE_ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH - BYTE_WIDTH;
    localparam int LINE_WIDTH   = `CACHE_WORDS * `CACHE_WORD_WIDTH;

    typedef logic [INDEX_WIDTH-1:0]       index_t;
    typedef logic [OFFSET_WIDTH-1:0]      offset_t;
    typedef logic [TAG_WIDTH-1:0]         tag_t;
    typedef logic [`CACHE_WORD_WIDTH-1:0] word_t;
    // Word 0 sits in the least significant bits of a line
    typedef logic [LINE_WIDTH-1:0]        line_t;

    // One controller write, any mix of the four enables may be set
    typedef struct packed {
        index_t  index;
        tag_t    tag;
        offset_t offset;
        word_t   data;
        logic    write_tag;
        logic    write_word;
        logic    write_valid;
        logic    write_dirty;
        logic    valid;
        logic    dirty;
    } update_req_t;

    typedef struct packed {
        tag_t    tag;
        index_t  index;
        offset_t offset;
    } lookup_req_t;

    typedef struct packed {
        logic valid;
        logic dirty;
    } status_t;

    // Resident tag and dirty bit let the controller address a write-back
    typedef struct packed {
        logic  hit;
        logic  valid;
        logic  dirty;
        tag_t  tag;
        word_t data;
    } lookup_rsp_t;

endpackage

//--- design/status_memory.sv
//--------------------------------------------------------------------------
// Valid and dirty bits of every cache line. Each bit bank has its own
// write enable, and one registered read port returns both bits of a line.
//--------------------------------------------------------------------------

`timescale 1ns/1ps

`include "cache_defs.svh"

module status_memory (
    input  logic               clk_i,
    input  logic               arst_n_i,

    // Write port driven by the cache controller
    input  cache_pkg::index_t  wr_index_i,
    input  logic               wr_valid_en_i,
    input  logic               wr_dirty_en_i,
    input  cache_pkg::status_t wr_status_i,

    // Read port driven by the lookup path
    input  logic               rd_en_i,
    input  cache_pkg::index_t  rd_index_i,
    output cache_pkg::status_t rd_status_o
);

    //----------------------------------------------------------------------
    // Bit banks
    //----------------------------------------------------------------------

    // One flop per line in each bank, so the whole bank clears at once
    logic [`CACHE_DEPTH-1:0] valid_bank;
    logic [`CACHE_DEPTH-1:0] dirty_bank;

    // Both banks share the write index but never each other's enable
    // A line can be marked dirty while its valid bit stays untouched
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_bank <= '0;
            dirty_bank <= '0;
        end else begin
            if (wr_valid_en_i) begin
                valid_bank[wr_index_i] <= wr_status_i.valid;
            end
            if (wr_dirty_en_i) begin
                dirty_bank[wr_index_i] <= wr_status_i.dirty;
            end
        end
    end

    //----------------------------------------------------------------------
    // Registered read
    //----------------------------------------------------------------------

    // The banks are sampled before this edge's write takes effect
    // So a read and a write to the same line return the old bits
    // The output holds its last value while no read is requested
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rd_status_o <= '0;
        end else if (rd_en_i) begin
            rd_status_o.valid <= valid_bank[rd_index_i];
            rd_status_o.dirty <= dirty_bank[rd_index_i];
        end
    end

endmodule

//--- design/tag_memory.sv
//--------------------------------------------------------------------------
// Tag array of the cache, one tag per line. Simple dual-port RAM with a
// write port for the controller and a registered read port for lookups.
//--------------------------------------------------------------------------

`timescale 1ns/1ps

`include "cache_defs.svh"

module tag_memory (
    input  logic              clk_i,

    // Write port, a tag is written when a line is filled
    input  logic              wr_en_i,
    input  cache_pkg::index_t wr_index_i,
    input  cache_pkg::tag_t   wr_tag_i,

    // Read port, addressed by the lookup index
    input  logic              rd_en_i,
    input  cache_pkg::index_t rd_index_i,
    output cache_pkg::tag_t   rd_tag_o
);

    import cache_pkg::*;

    // Contents are undefined until the controller fills a line
    // Without a reset the array maps onto block or distributed RAM
    tag_t tag_ram [`CACHE_DEPTH];

    // Write side
    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            tag_ram[wr_index_i] <= wr_tag_i;
        end
    end

    // Read side with an output register and read-before-write behaviour
    // A read and a write to the same index in one cycle give the old tag
    always_ff @(posedge clk_i) begin
        if (rd_en_i) begin
            rd_tag_o <= tag_ram[rd_index_i];
        end
    end

endmodule

//--- design/data_memory.sv
//--------------------------------------------------------------------------
// Line data of the cache, held as one RAM column per word so a single
// word can be written alone. The read port registers the whole line.
//--------------------------------------------------------------------------

`timescale 1ns/1ps

`include "cache_defs.svh"

module data_memory (
    input  logic                 clk_i,

    // Word write port, one word of one line per cycle
    input  logic                 wr_en_i,
    input  cache_pkg::index_t    wr_index_i,
    input  cache_pkg::offset_t   wr_offset_i,
    input  cache_pkg::word_t     wr_word_i,

    // Line read port, all words of the addressed line at once
    input  logic                 rd_en_i,
    input  cache_pkg::index_t    rd_index_i,
    output cache_pkg::line_t     rd_line_o
);

    import cache_pkg::*;

    //----------------------------------------------------------------------
    // Word columns
    //----------------------------------------------------------------------

    // Each column is an independent RAM with its own write enable
    // The word select for a lookup happens after this output register
    for (genvar w = 0; w < `CACHE_WORDS; w++) begin : g_column

        word_t column_ram [`CACHE_DEPTH];

        // Only the column picked by the offset takes the write
        always_ff @(posedge clk_i) begin
            if (wr_en_i && (wr_offset_i == offset_t'(w))) begin
                column_ram[wr_index_i] <= wr_word_i;
            end
        end

        // Registered read of this column into its slice of the line
        // A write in the same cycle is not visible until the next read
        always_ff @(posedge clk_i) begin
            if (rd_en_i) begin
                rd_line_o[w*`CACHE_WORD_WIDTH +: `CACHE_WORD_WIDTH] <=
                    column_ram[rd_index_i];
            end
        end

    end : g_column

endmodule

//--- design/lookup_stage.sv
//--------------------------------------------------------------------------
// Back end of the lookup path. Delays the request by one cycle to meet
// the array outputs, then compares tags, selects the word and registers
// the response, two cycles after the request was accepted.
//--------------------------------------------------------------------------

`timescale 1ns/1ps

`include "cache_defs.svh"

module lookup_stage (
    input  logic                   clk_i,
    input  logic                   arst_n_i,

    // Request, presented in the same cycle as the array reads
    input  logic                   req_en_i,
    input  cache_pkg::lookup_req_t req_i,

    // Array outputs, one cycle after the request
    input  cache_pkg::status_t     status_i,
    input  cache_pkg::tag_t        tag_i,
    input  cache_pkg::line_t       line_i,

    // Response, valid for exactly one cycle
    output logic                   rsp_valid_o,
    output cache_pkg::lookup_rsp_t rsp_o
);

    import cache_pkg::*;

    //----------------------------------------------------------------------
    // Stage 1, request alignment
    //----------------------------------------------------------------------

    logic    req_en_q;
    tag_t    req_tag_q;
    offset_t req_offset_q;

    // Only the enable is control state and needs a reset
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            req_en_q <= 1'b0;
        end else begin
            req_en_q <= req_en_i;
        end
    end

    // Tag and offset travel alongside the array read of the same request
    always_ff @(posedge clk_i) begin
        if (req_en_i) begin
            req_tag_q    <= req_i.tag;
            req_offset_q <= req_i.offset;
        end
    end

    //----------------------------------------------------------------------
    // Stage 2, compare and select
    //----------------------------------------------------------------------

    logic  hit;
    word_t sel_word;

    // A hit needs a valid line and a matching resident tag
    assign hit = status_i.valid && (req_tag_q == tag_i);

    // Pick the addressed word out of the registered line
    always_comb begin
        sel_word = line_i[`CACHE_WORD_WIDTH-1:0];
        for (int w = 1; w < `CACHE_WORDS; w++) begin
            if (req_offset_q == offset_t'(w)) begin
                sel_word = line_i[w*`CACHE_WORD_WIDTH +: `CACHE_WORD_WIDTH];
            end
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rsp_valid_o <= 1'b0;
        end else begin
            rsp_valid_o <= req_en_q;
        end
    end

    // Dirty is passed on as stored, even for an invalid line
    always_ff @(posedge clk_i) begin
        if (req_en_q) begin
            rsp_o.hit   <= hit;
            rsp_o.valid <= status_i.valid;
            rsp_o.dirty <= status_i.dirty;
            rsp_o.tag   <= tag_i;
            rsp_o.data  <= sel_word;
        end
    end

endmodule

//--- design/cache_memory_top.sv
//--------------------------------------------------------------------------
// Storage and lookup block of a direct-mapped write-back data cache. The
// update port writes the arrays, the lookup port answers two cycles later.
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module cache_memory_top (
    input  logic                   clk_i,
    input  logic                   arst_n_i,

    // Update port from the cache controller
    input  logic                   upd_en_i,
    input  cache_pkg::update_req_t upd_req_i,

    // Lookup port, fixed latency of two cycles and no stall
    input  logic                   lkp_en_i,
    input  cache_pkg::lookup_req_t lkp_req_i,
    output logic                   rsp_valid_o,
    output cache_pkg::lookup_rsp_t rsp_o
);

    import cache_pkg::*;

    // Array read data, one cycle after the lookup was accepted
    status_t rd_status;
    tag_t    rd_tag;
    line_t   rd_line;

    // New status bits for the status banks
    status_t wr_status;

    assign wr_status.valid = upd_req_i.valid;
    assign wr_status.dirty = upd_req_i.dirty;

    //----------------------------------------------------------------------
    // Arrays
    //----------------------------------------------------------------------

    // Every write enable is qualified by the update port enable
    status_memory u_status_memory (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .wr_index_i    (upd_req_i.index),
        .wr_valid_en_i (upd_en_i && upd_req_i.write_valid),
        .wr_dirty_en_i (upd_en_i && upd_req_i.write_dirty),
        .wr_status_i   (wr_status),
        .rd_en_i       (lkp_en_i),
        .rd_index_i    (lkp_req_i.index),
        .rd_status_o   (rd_status)
    );

    tag_memory u_tag_memory (
        .clk_i      (clk_i),
        .wr_en_i    (upd_en_i && upd_req_i.write_tag),
        .wr_index_i (upd_req_i.index),
        .wr_tag_i   (upd_req_i.tag),
        .rd_en_i    (lkp_en_i),
        .rd_index_i (lkp_req_i.index),
        .rd_tag_o   (rd_tag)
    );

    data_memory u_data_memory (
        .clk_i       (clk_i),
        .wr_en_i     (upd_en_i && upd_req_i.write_word),
        .wr_index_i  (upd_req_i.index),
        .wr_offset_i (upd_req_i.offset),
        .wr_word_i   (upd_req_i.data),
        .rd_en_i     (lkp_en_i),
        .rd_index_i  (lkp_req_i.index),
        .rd_line_o   (rd_line)
    );

    //----------------------------------------------------------------------
    // Lookup back end
    //----------------------------------------------------------------------

    // Sees the request in the same cycle as the arrays do
    lookup_stage u_lookup_stage (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .req_en_i    (lkp_en_i),
        .req_i       (lkp_req_i),
        .status_i    (rd_status),
        .tag_i       (rd_tag),
        .line_i      (rd_line),
        .rsp_valid_o (rsp_valid_o),
        .rsp_o       (rsp_o)
    );

endmodule

//--- tests/tb_cache_memory.sv
//--------------------------------------------------------------------------
// Random-stimulus testbench of the cache storage block. A model of the
// status, tag and data arrays predicts every lookup response.
//--------------------------------------------------------------------------

`timescale 1ns/1ps

`include "cache_defs.svh"

module tb_cache_memory;

    import cache_pkg::*;

    localparam int RESET_CYCLES = 10;
    localparam int QUIET_CYCLES = 40;
    localparam int MIXED_CYCLES = 3000;
    localparam int TOTAL_CYCLES = QUIET_CYCLES + MIXED_CYCLES + 4;
    localparam int WATCHDOG_NS  = (RESET_CYCLES + TOTAL_CYCLES + 100) * 10;

    // Expected response, with flags for the fields the model can predict
    typedef struct packed {
        lookup_rsp_t rsp;
        logic        hit_known;
        logic        tag_known;
        logic        data_known;
        int unsigned issue;
    } expect_t;

    logic clk_i, arst_n_i, upd_en_i, lkp_en_i, rsp_valid_o;
    update_req_t upd_req_i;
    lookup_req_t lkp_req_i;
    lookup_rsp_t rsp_o;

    integer      seed;
    int unsigned cyc, errors, lookups, hits;
    expect_t     pending [$];

    // Reference state, tag and data are unknown until first written
    logic  m_valid [`CACHE_DEPTH];
    logic  m_dirty [`CACHE_DEPTH];
    tag_t  m_tag [`CACHE_DEPTH];
    logic  m_tag_known [`CACHE_DEPTH];
    word_t m_data [`CACHE_DEPTH][`CACHE_WORDS];
    logic  m_word_known [`CACHE_DEPTH][`CACHE_WORDS];

    cache_memory_top DUT (.*);

    always #5 clk_i = ~clk_i;

    //----------------------------------------------------------------------
    // Address helpers
    //----------------------------------------------------------------------

    // Byte address layout is tag [31:10], index [9:4], word [3:2]
    function automatic lookup_req_t split_addr(input logic [31:0] addr);
        lookup_req_t r;
        r.tag    = addr[31:10];
        r.index  = addr[9:4];
        r.offset = addr[3:2];
        return r;
    endfunction

    // Eight lines in use, spread over the index range
    function automatic index_t pool_index(input logic [2:0] line_sel);
        return {line_sel, 3'b011};
    endfunction

    // Three tags compete for each line, so conflicts are common
    function automatic tag_t pool_tag(input logic [2:0] line_sel, input logic [1:0] sel);
        return {12'h5a3, 2'b01, line_sel, 3'b110, (sel == 2'd3) ? 2'd0 : sel};
    endfunction

    task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (act !== exp) begin
            $display("Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    //----------------------------------------------------------------------
    // Model and response check
    //----------------------------------------------------------------------

    // A lookup driven in cycle N is taken at the next rising edge and its
    // response is registered one edge later, so it is seen in cycle N+2
    task automatic check_response();
        expect_t e;
        if (rsp_valid_o) begin
            if (pending.size() == 0 || pending[0].issue + 2 != cyc) begin
                $display("Response at %0t ns with no lookup waiting for it", $time);
                errors++;
            end else begin
                e = pending.pop_front();
                lookups++;
                check("rsp_o.valid", 64'(e.rsp.valid), 64'(rsp_o.valid));
                check("rsp_o.dirty", 64'(e.rsp.dirty), 64'(rsp_o.dirty));
                if (e.hit_known) check("rsp_o.hit", 64'(e.rsp.hit), 64'(rsp_o.hit));
                if (e.tag_known) check("rsp_o.tag", 64'(e.rsp.tag), 64'(rsp_o.tag));
                if (e.data_known) check("rsp_o.data", 64'(e.rsp.data), 64'(rsp_o.data));
                if (e.rsp.hit) hits++;
            end
        end else if (pending.size() != 0 && pending[0].issue + 2 == cyc) begin
            $display("No response at %0t ns for the lookup of cycle %0d",
                     $time, pending[0].issue);
            errors++;
            void'(pending.pop_front());
        end
    endtask

    // Lookup sees the state before the update taken at the same edge
    task automatic apply_accepted();
        expect_t e;
        index_t  i;
        i = lkp_req_i.index;
        if (lkp_en_i) begin
            // Driven in the previous cycle and taken at the edge just gone
            e.issue      = cyc - 1;
            e.rsp.valid  = m_valid[i];
            e.rsp.dirty  = m_dirty[i];
            e.rsp.tag    = m_tag[i];
            e.tag_known  = m_tag_known[i];
            e.hit_known  = m_tag_known[i] || !m_valid[i];
            e.rsp.hit    = m_valid[i] && m_tag_known[i] && (m_tag[i] == lkp_req_i.tag);
            e.rsp.data   = m_data[i][lkp_req_i.offset];
            e.data_known = e.rsp.hit && m_word_known[i][lkp_req_i.offset];
            pending.push_back(e);
        end
        i = upd_req_i.index;
        if (upd_en_i && upd_req_i.write_valid) m_valid[i] = upd_req_i.valid;
        if (upd_en_i && upd_req_i.write_dirty) m_dirty[i] = upd_req_i.dirty;
        if (upd_en_i && upd_req_i.write_tag) begin
            m_tag[i]       = upd_req_i.tag;
            m_tag_known[i] = 1'b1;
        end
        if (upd_en_i && upd_req_i.write_word) begin
            m_data[i][upd_req_i.offset]       = upd_req_i.data;
            m_word_known[i][upd_req_i.offset] = 1'b1;
        end
    endtask

    // Lookups on three cycles of four, updates on about half the cycles
    task automatic drive_random(input bit allow_update);
        logic [31:0] rnd;
        rnd = $random(seed);
        lkp_en_i  = (rnd[8:7] != 2'b00) && (cyc < QUIET_CYCLES + MIXED_CYCLES);
        lkp_req_i = split_addr({pool_tag(rnd[2:0], rnd[4:3]), pool_index(rnd[2:0]),
                                rnd[6:5], 2'b00});
        rnd = $random(seed);
        upd_en_i              = allow_update && rnd[0];
        upd_req_i.index       = rnd[11] ? lkp_req_i.index : pool_index(rnd[3:1]);
        upd_req_i.tag         = pool_tag(upd_req_i.index[5:3], rnd[5:4]);
        upd_req_i.offset      = rnd[7:6];
        upd_req_i.write_tag   = rnd[12];
        upd_req_i.write_word  = rnd[13] | rnd[14];
        upd_req_i.write_valid = rnd[15];
        upd_req_i.write_dirty = rnd[16];
        upd_req_i.valid       = (rnd[18:17] != 2'b00);
        upd_req_i.dirty       = rnd[19];
        upd_req_i.data        = $random(seed);
    endtask

    //----------------------------------------------------------------------
    // Test sequence
    //----------------------------------------------------------------------

    initial begin
        seed = 32'hdb93_f0b1;
        {clk_i, arst_n_i, upd_en_i, lkp_en_i, cyc, errors, lookups, hits} = '0;
        upd_req_i = '0;
        lkp_req_i = '0;
        for (int i = 0; i < `CACHE_DEPTH; i++) begin
            {m_valid[i], m_dirty[i], m_tag_known[i], m_tag[i]} = '0;
            for (int w = 0; w < `CACHE_WORDS; w++) {m_word_known[i][w], m_data[i][w]} = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk_i);
        @(negedge clk_i);
        arst_n_i = 1'b1;
        // Lookups alone first, so every line reads back as reset
        for (cyc = 0; cyc < TOTAL_CYCLES; cyc++) begin
            @(negedge clk_i);
            check_response();
            apply_accepted();
            drive_random(cyc >= QUIET_CYCLES && cyc < QUIET_CYCLES + MIXED_CYCLES);
        end
        if (pending.size() != 0) begin
            $display("%0d lookups never received a response", pending.size());
            errors++;
        end
        $display("Lookups checked: %0d, hits: %0d, errors: %0d", lookups, hits, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout after %0d ns, the test loop did not complete", WATCHDOG_NS);
        $display("TEST FAILED");
        $finish;
    end

endmodule

//--- compile.f
+incdir+design
design/cache_pkg.sv
design/status_memory.sv
design/tag_memory.sv
design/data_memory.sv
design/lookup_stage.sv
design/cache_memory_top.sv
tests/tb_cache_memory.sv

//--- run_sim.sh
#!/bin/sh
# Builds the cache storage testbench with Verilator and runs it.
# Exits non-zero when the build, the run or the result check fails.

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -f compile.f --top-module tb_cache_memory \
    -Mdir obj_dir -o tb_cache_memory
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_cache_memory > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST OK$" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
